/* src.f */
+incdir+hw
hw/ccu_pkg.sv
hw/isaDecoder.sv
hw/cfgDeserializer.sv
hw/ccuTop.sv
testbench/ccu_asserts.sv
testbench/ccuTb.sv

/* run.sh */
#!/usr/bin/env bash
# Compile with Verilator, run the testbench and decide pass or fail from the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f src.f \
    --top-module ccuTb \
    -o ccuSim
if [ $? -ne 0 ]; then
    echo "Compile failed"
    exit 1
fi

./obj_dir/ccuSim > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -q "Done: no errors" sim.log; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi

/* testbench/ccuTb.sv */
// Directed testbench for the CCU top level, run as the simulation top from the file list
`include "ccu_params.svh"

module ccuTb
    import ccuPkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int MAX_CYCLES = 3000;   // About 60 instructions of up to 40 cycles, plus reset

    logic                  clk;
    logic                  rst_n;
    logic [`ISA_WIDTH-1:0] isaDat;
    logic                  isaVld;
    logic                  isaRdy;
    logic                  itfCfgVld;
    logic                  knnCfgVld;
    logic                  syaCfgVld;
    logic [2:0]            cfgRdy;      // ITF, KNN, SYA
    itfCfg_t               itfCfg;
    knnCfg_t               knnCfg;
    syaCfg_t               syaCfg;

    int                    seed;
    int                    cycles;
    int                    holdCnt [3];  // Ready-low cycles still owed per unit
    logic [`ISA_WIDTH-1:0] wordQ [$];    // Words of the instruction being built
    int                    obsUnit [$];
    logic [255:0]          obsDat [$];
    logic [255:0]          expVec;
    logic [7:0]            fInOut;
    logic [31:0]           fDram;
    logic [15:0]           fGlb;
    logic [15:0]           fNum;
    logic [15:0]           fNip;
    logic [7:0]            fK;
    logic [15:0]           fMap;

    ccuTop u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .isaDat    (isaDat),
        .isaVld    (isaVld),
        .isaRdy    (isaRdy),
        .itfCfgVld (itfCfgVld),
        .itfCfgRdy (cfgRdy[0]),
        .itfCfg    (itfCfg),
        .knnCfgVld (knnCfgVld),
        .knnCfgRdy (cfgRdy[1]),
        .knnCfg    (knnCfg),
        .syaCfgVld (syaCfgVld),
        .syaCfgRdy (cfgRdy[2]),
        .syaCfg    (syaCfg)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ========================================================================
    // Unit ready drivers and output monitor
    // ========================================================================
    always @(negedge clk) begin
        for (int u = 0; u < 3; u++) begin
            if (holdCnt[u] > 0) begin
                cfgRdy[u] = 1'b0;
                if ({syaCfgVld, knnCfgVld, itfCfgVld}[u]) begin
                    holdCnt[u] = holdCnt[u] - 1;   // Counts only while valid waits
                end
            end else begin
                cfgRdy[u] = 1'b1;
            end
        end
    end

    always @(posedge clk) begin
        if (itfCfgVld && cfgRdy[0]) begin
            obsUnit.push_back(0);
            obsDat.push_back(256'(itfCfg));
        end
        if (knnCfgVld && cfgRdy[1]) begin
            obsUnit.push_back(1);
            obsDat.push_back(256'(knnCfg));
        end
        if (syaCfgVld && cfgRdy[2]) begin
            obsUnit.push_back(2);
            obsDat.push_back(256'(syaCfg));
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > MAX_CYCLES) begin
            $display("Timeout: the DUT stopped making progress");
            $display("Done: errors found");
            $fatal(1, "run aborted");
        end
    end

    // ========================================================================
    // Helpers
    // ========================================================================
    task automatic checkVal(input string name, input logic [255:0] exp, input logic [255:0] act);
        if (exp !== act) begin
            $display("ERROR %s expected %h actual %h", name, exp, act);
            $display("Done: errors found");
            $fatal(1, "mismatch");
        end
    endtask

    task automatic randWord(output logic [`ISA_WIDTH-1:0] w);
        w = {$random(seed), $random(seed), $random(seed), $random(seed)};
    endtask

    // Builds one instruction into wordQ with fields at their documented offsets
    task automatic genInstr(input int unit, input logic [7:0] opc);
        logic [`ISA_WIDTH-1:0] w0;
        logic [`ISA_WIDTH-1:0] w1;
        logic [31:0]           r;
        randWord(w0);
        randWord(w1);
        r = $random(seed);
        fInOut = {7'd0, r[0]};
        fDram  = $random(seed);
        r = $random(seed);
        fGlb = r[15:0];
        fNum = r[31:16];
        fNip = r[23:8];
        fK   = r[7:0];
        r = $random(seed);
        fMap = r[15:0];
        w0[7:0] = opc;
        wordQ.delete();
        if (unit == 0) begin
            w0[15:8]  = fInOut;
            w0[47:16] = fDram;
            w0[63:48] = fGlb;
            w0[79:64] = fNum;
        end else if (unit == 1) begin
            w0[23:8]  = fNip;
            w0[31:24] = fK;
            w0[63:48] = fMap;
        end
        wordQ.push_back(w0);
        if (unit != 0 && unit != 3) begin
            wordQ.push_back(w1);
        end
        if (wordQ.size() == 1) begin
            expVec = {128'd0, wordQ[0]} >> 8;   // Opcode byte dropped
        end else begin
            expVec = {wordQ[1], wordQ[0]} >> 8;
        end
    endtask

    task automatic sendInstr(input int maxGap);
        logic [31:0] r;
        for (int i = 0; i < wordQ.size(); i++) begin
            r = $random(seed);
            repeat ((maxGap > 0) ? int'(r[3:0]) % (maxGap + 1) : 0) begin
                @(negedge clk);
                isaVld = 1'b0;
            end
            @(negedge clk);
            isaVld = 1'b1;
            isaDat = wordQ[i];
            @(posedge clk);
            while (!isaRdy) @(posedge clk);
        end
        @(negedge clk);
        isaVld = 1'b0;
    endtask

    task automatic checkNextObs(input string name, input int unit, input logic [255:0] exp);
        while (obsUnit.size() == 0) @(posedge clk);
        checkVal({name, " unit"}, 256'(unit), 256'(obsUnit.pop_front()));
        checkVal({name, " cfg"}, exp, obsDat.pop_front());
    endtask

    task automatic checkIdle(input string name, input int n);
        repeat (n) begin
            @(posedge clk);
            checkVal(name, 256'(4'b0000), 256'({isaRdy, syaCfgVld, knnCfgVld, itfCfgVld}));
        end
    endtask

    // ========================================================================
    // Directed tests
    // ========================================================================
    task automatic testReset();
        checkIdle("reset", 4);
    endtask

    task automatic testItf();
        itfCfg_t c;
        genInstr(0, 8'd5);
        sendInstr(0);
        while (obsUnit.size() == 0) @(posedge clk);
        checkVal("itf unit", 256'(0), 256'(obsUnit[0]));
        c = itfCfg_t'(obsDat[0][119:0]);
        checkVal("itf inOut", 256'(fInOut), 256'(c.inOut));
        checkVal("itf dramBaseAddr", 256'(fDram), 256'(c.dramBaseAddr));
        checkVal("itf glbBaseAddr", 256'(fGlb), 256'(c.glbBaseAddr));
        checkVal("itf num", 256'(fNum), 256'(c.num));
        checkNextObs("itf", 0, expVec);
        checkVal("itf only", 256'(0), 256'(obsUnit.size()));   // No other unit fired
    endtask

    task automatic testKnn();
        knnCfg_t c;
        genInstr(1, 8'd2);
        sendInstr(2);
        while (obsUnit.size() == 0) @(posedge clk);
        c = knnCfg_t'(obsDat[0][247:0]);
        checkVal("knn nip", 256'(fNip), 256'(c.nip));
        checkVal("knn k", 256'(fK), 256'(c.k));
        checkVal("knn mapWrAddr", 256'(fMap), 256'(c.mapWrAddr));
        checkNextObs("knn", 1, expVec);
    endtask

    task automatic testBackPressure();
        logic [255:0] syaExp;
        logic [255:0] held;
        holdCnt[2] = 10;
        genInstr(2, 8'd3);
        syaExp = expVec;
        sendInstr(0);
        genInstr(0, 8'd5);
        isaVld = 1'b1;   // ITF offered while the SYA config waits
        isaDat = wordQ[0];
        @(posedge clk);
        held = 256'(syaCfg);
        repeat (8) begin
            @(posedge clk);
            checkVal("bp isaRdy", 256'(0), 256'(isaRdy));
            checkVal("bp syaCfgVld", 256'(1), 256'(syaCfgVld));
            checkVal("bp syaCfg", held, 256'(syaCfg));
        end
        sendInstr(0);
        checkNextObs("bp sya", 2, syaExp);
        checkNextObs("bp itf", 0, expVec);
    endtask

    task automatic testUnknown();
        genInstr(3, 8'd1);
        sendInstr(0);
        checkIdle("unknown", 3);
        checkVal("unknown obs", 256'(0), 256'(obsUnit.size()));
        genInstr(1, 8'd2);
        sendInstr(0);
        checkNextObs("after unknown", 1, expVec);
    endtask

    task automatic testRandom();
        int           expUnit [$];
        logic [255:0] expQ [$];
        logic [31:0]  r;
        int           unit;
        for (int i = 0; i < 40; i++) begin
            r = $random(seed);
            unit = int'(r[7:0]) % 3;
            holdCnt[unit] = int'(r[9:8]);
            genInstr(unit, (unit == 0) ? 8'd5 : (unit == 1) ? 8'd2 : 8'd3);
            expUnit.push_back(unit);
            expQ.push_back(expVec);
            sendInstr(3);
        end
        foreach (expUnit[i]) begin
            checkNextObs($sformatf("random %0d", i), expUnit[i], expQ[i]);
        end
    endtask

    initial begin
        seed     = 53395;
        cycles   = 0;
        rst_n    = 1'b0;
        isaVld   = 1'b0;
        isaDat   = '0;
        cfgRdy   = 3'b111;
        for (int u = 0; u < 3; u++) begin
            holdCnt[u] = 0;
        end
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        testReset();
        testItf();
        testKnn();
        testBackPressure();
        testUnknown();
        testRandom();
        checkIdle("final", 2);
        $display("Done: no errors");
        $finish;
    end

endmodule

/* testbench/ccu_asserts.sv */
// Concurrent handshake assertions, bound onto the CCU top level for simulation
module ccuAsserts
    import ccuPkg::*;
(
    input logic    clk,
    input logic    rst_n,
    input logic    isaRdy,
    input logic    itfCfgVld,
    input logic    itfCfgRdy,
    input itfCfg_t itfCfg,
    input logic    knnCfgVld,
    input logic    knnCfgRdy,
    input knnCfg_t knnCfg,
    input logic    syaCfgVld,
    input logic    syaCfgRdy,
    input syaCfg_t syaCfg
);
    timeunit 1ns;
    timeprecision 1ps;

    // Valid and data hold until the unit takes them
    itfHold: assert property (@(posedge clk) disable iff (!rst_n)
        itfCfgVld && !itfCfgRdy |=> itfCfgVld && $stable(itfCfg)) else $error("itf hold");
    knnHold: assert property (@(posedge clk) disable iff (!rst_n)
        knnCfgVld && !knnCfgRdy |=> knnCfgVld && $stable(knnCfg)) else $error("knn hold");
    syaHold: assert property (@(posedge clk) disable iff (!rst_n)
        syaCfgVld && !syaCfgRdy |=> syaCfgVld && $stable(syaCfg)) else $error("sya hold");

    oneValid: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({itfCfgVld, knnCfgVld, syaCfgVld})) else $error("several valids");

    // Stream stalls while any config is pending
    noReadyWhileVld: assert property (@(posedge clk) disable iff (!rst_n)
        !(isaRdy && (itfCfgVld || knnCfgVld || syaCfgVld))) else $error("isaRdy with valid");

endmodule

bind ccuTop ccuAsserts u_asserts (.*);

/* hw/ccuTop.sv */
// Top level of the configuration control unit, joining the decoder and the three deserializers
`include "ccu_params.svh"

module ccuTop
    import ccuPkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [`ISA_WIDTH-1:0] isaDat,
    input  logic                  isaVld,
    output logic                  isaRdy,
    // Off-chip interface
    output logic                  itfCfgVld,
    input  logic                  itfCfgRdy,
    output itfCfg_t               itfCfg,
    // Neighbour search
    output logic                  knnCfgVld,
    input  logic                  knnCfgRdy,
    output knnCfg_t               knnCfg,
    // Systolic array
    output logic                  syaCfgVld,
    input  logic                  syaCfgRdy,
    output syaCfg_t               syaCfg
);

    logic [2:0]                       inRdy;    // ITF, KNN, SYA
    logic [2:0]                       inVld;
    logic [`ITF_WORDS*`ISA_WIDTH-1:0] itfVec;
    logic [`KNN_WORDS*`ISA_WIDTH-1:0] knnVec;
    logic [`SYA_WORDS*`ISA_WIDTH-1:0] syaVec;

    isaDecoder u_decoder (
        .clk    (clk),
        .rst_n  (rst_n),
        .isaDat (isaDat[`OPCODE_WIDTH-1:0]),
        .isaVld (isaVld),
        .isaRdy (isaRdy),
        .inRdy  (inRdy),
        .outVld ({syaCfgVld, knnCfgVld, itfCfgVld}),
        .cfgRdy ({syaCfgRdy, knnCfgRdy, itfCfgRdy}),
        .inVld  (inVld)
    );

    // =========================================================================
    // Deserializers sharing the instruction stream
    // =========================================================================
    cfgDeserializer #(.WORDS(`ITF_WORDS)) u_itfDes (
        .clk    (clk),
        .rst_n  (rst_n),
        .inVld  (inVld[0]),
        .inDat  (isaDat),
        .inRdy  (inRdy[0]),
        .outDat (itfVec),
        .outVld (itfCfgVld),
        .outRdy (itfCfgRdy)
    );

    cfgDeserializer #(.WORDS(`KNN_WORDS)) u_knnDes (
        .clk    (clk),
        .rst_n  (rst_n),
        .inVld  (inVld[1]),
        .inDat  (isaDat),
        .inRdy  (inRdy[1]),
        .outDat (knnVec),
        .outVld (knnCfgVld),
        .outRdy (knnCfgRdy)
    );

    cfgDeserializer #(.WORDS(`SYA_WORDS)) u_syaDes (
        .clk    (clk),
        .rst_n  (rst_n),
        .inVld  (inVld[2]),
        .inDat  (isaDat),
        .inRdy  (inRdy[2]),
        .outDat (syaVec),
        .outVld (syaCfgVld),
        .outRdy (syaCfgRdy)
    );

    // Opcode byte dropped, the rest maps straight onto each struct
    assign itfCfg = itfCfg_t'(itfVec[`ITF_WORDS*`ISA_WIDTH-1:`OPCODE_WIDTH]);
    assign knnCfg = knnCfg_t'(knnVec[`KNN_WORDS*`ISA_WIDTH-1:`OPCODE_WIDTH]);
    assign syaCfg = syaCfg_t'(syaVec[`SYA_WORDS*`ISA_WIDTH-1:`OPCODE_WIDTH]);

endmodule

/* hw/cfgDeserializer.sv */
// Collects WORDS instruction words into one configuration vector and holds it until accepted
`include "ccu_params.svh"

module cfgDeserializer #(
    parameter int WORDS = 1
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        inVld,
    input  logic [`ISA_WIDTH-1:0]       inDat,
    output logic                        inRdy,
    output logic [WORDS*`ISA_WIDTH-1:0] outDat,   // First word in the low bits
    output logic                        outVld,
    input  logic                        outRdy
);

    localparam int CNT_W = (WORDS > 1) ? $clog2(WORDS) : 1;
    localparam logic [CNT_W-1:0] LAST_WORD = CNT_W'(WORDS - 1);

    logic [CNT_W-1:0] cnt;     // Words taken so far
    logic             inHs;
    logic             outHs;

    // Input closed while a finished vector waits
    assign inRdy = !outVld;
    assign inHs  = inVld && inRdy;
    assign outHs = outVld && outRdy;

    // =========================================================================
    // Word counter and output valid
    // =========================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt    <= '0;
            outVld <= 1'b0;
        end else if (inHs) begin
            if (cnt == LAST_WORD) begin
                cnt    <= '0;
                outVld <= 1'b1;   // Vector complete
            end else begin
                cnt <= cnt + 1'b1;
            end
        end else if (outHs) begin
            outVld <= 1'b0;
        end
    end

    // =========================================================================
    // Assembly register
    // =========================================================================
    // Each word lands in its own slot, LSB first
    always_ff @(posedge clk) begin
        if (inHs) begin
            outDat[cnt*`ISA_WIDTH +: `ISA_WIDTH] <= inDat;
        end
    end

endmodule

/* hw/isaDecoder.sv */
// Opcode-latching FSM that grants the instruction stream to one deserializer per instruction
`include "ccu_params.svh"

module isaDecoder
    import ccuPkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [`OPCODE_WIDTH-1:0] isaDat,   // Opcode byte of the current word
    input  logic                     isaVld,
    output logic                     isaRdy,
    input  logic [2:0]               inRdy,    // Index order ITF, KNN, SYA
    input  logic [2:0]               outVld,
    input  logic [2:0]               cfgRdy,
    output logic [2:0]               inVld
);

    decState_e  state;
    decState_e  nextState;
    opcode_e    opcode;
    logic [2:0] grant;
    logic       known;     // Opcode has a unit behind it
    logic       cfgDone;   // Granted unit took its configuration

    // =========================================================================
    // Grant
    // =========================================================================
    always_comb begin
        case (opcode)
            ITF:     grant = 3'b001;
            KNN:     grant = 3'b010;
            SYA:     grant = 3'b100;
            default: grant = 3'b000;   // CCU and unused codes
        endcase
    end

    assign known   = |grant;
    assign cfgDone = |(grant & outVld & cfgRdy);

    // =========================================================================
    // FSM
    // =========================================================================
    always_comb begin
        nextState = state;
        case (state)
            IDLE: begin
                if (isaVld) begin
                    nextState = DEC;
                end
            end
            DEC: begin
                if (known) begin
                    if (cfgDone) begin
                        nextState = IDLE;
                    end
                end else if (isaVld) begin
                    nextState = IDLE;   // Lone word swallowed
                end
            end
            default: nextState = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= IDLE;
            opcode <= CCU;
        end else begin
            state <= nextState;
            if (state == IDLE && isaVld) begin
                opcode <= opcode_e'(isaDat);   // Peek only, word stays on the bus
            end
        end
    end

    // Stream goes to the granted unit, or is drained for an unknown code
    assign inVld  = (state == DEC) ? (grant & {3{isaVld}}) : 3'b000;
    assign isaRdy = (state == DEC) && (known ? |(grant & inRdy) : isaVld);

endmodule

/* hw/ccu_pkg.sv */
// Decoder state, opcode and per-unit configuration types, imported by the decoder and top level
`include "ccu_params.svh"

package ccuPkg;

    typedef enum logic [1:0] {
        IDLE = 2'd0,   // Waiting for a first word
        DEC  = 2'd1    // Stream granted to one unit
    } decState_e;

    // Codes 1 and 4 have no unit and are dropped by the decoder
    typedef enum logic [`OPCODE_WIDTH-1:0] {
        CCU = 'd0,
        KNN = 'd2,
        SYA = 'd3,
        ITF = 'd5
    } opcode_e;

    // Off-chip transfer, one word
    typedef struct packed {
        logic [`ITF_WORDS*`ISA_WIDTH-`OPCODE_WIDTH-2*`ADDR_WIDTH-`DRAM_ADDR_WIDTH-9:0] rsvd;
        logic [`ADDR_WIDTH-1:0]      num;
        logic [`ADDR_WIDTH-1:0]      glbBaseAddr;
        logic [`DRAM_ADDR_WIDTH-1:0] dramBaseAddr;
        logic [7:0]                  inOut;          // 0 into chip, 1 out to DRAM
    } itfCfg_t;

    // Neighbour search, two words, upper bits reserved
    typedef struct packed {
        logic [`KNN_WORDS*`ISA_WIDTH-`OPCODE_WIDTH-3*`ADDR_WIDTH-9:0] rsvd;
        logic [`ADDR_WIDTH-1:0] mapWrAddr;
        logic [`ADDR_WIDTH-1:0] crdRdAddr;
        logic [7:0]             k;
        logic [`ADDR_WIDTH-1:0] nip;
    } knnCfg_t;

    // Systolic array, two words, upper bits reserved
    typedef struct packed {
        logic [`SYA_WORDS*`ISA_WIDTH-`OPCODE_WIDTH-7*`ADDR_WIDTH-41:0] rsvd;
        logic [`ADDR_WIDTH-1:0] ofmWrBaseAddr;
        logic [`ADDR_WIDTH-1:0] wgtRdBaseAddr;
        logic [`ADDR_WIDTH-1:0] actRdBaseAddr;
        logic [7:0]             loopOrder;
        logic [`ADDR_WIDTH-1:0] numTilIfm;
        logic [`ADDR_WIDTH-1:0] numTilFlt;
        logic [`ADDR_WIDTH-1:0] numGrpPerTile;
        logic [`ADDR_WIDTH-1:0] chn;
        logic [7:0]             zeroPoint;
        logic [7:0]             shift;
        logic [7:0]             ofmPhaseShift;
        logic [7:0]             mode;
    } syaCfg_t;

endpackage

/* hw/ccu_params.svh */
// Widths and per-unit word counts for the CCU, included by the package and every RTL file
`ifndef CCU_PARAMS_SVH
`define CCU_PARAMS_SVH

// =========================================================================
// Bus and field widths
// =========================================================================
`define ISA_WIDTH        128   // One instruction word
`define OPCODE_WIDTH     8     // Low byte of the first word
`define ADDR_WIDTH       16    // Address, count and channel fields
`define DRAM_ADDR_WIDTH  32    // Off-chip address

// =========================================================================
// Instruction length per unit, in words
// =========================================================================
`define ITF_WORDS        1
`define KNN_WORDS        2
`define SYA_WORDS        2

`endif
